// File: hw/btbPkg.sv
// Shared widths, types and address helpers for the branch target buffer.
// Compile this first. Other files refer to it with btbPkg:: names.
package btbPkg;

    // Address and size constants
    localparam int PC_WIDTH = 32;
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET = $clog2(INSN_BYTES);
    localparam int FETCH_WIDTH = 2;
    localparam int RESOLVE_WIDTH = 2;

    localparam int BTB_ENTRY_NUM = 64;
    localparam int BTB_INDEX_WIDTH = 6;
    localparam int BTB_BANK_NUM = 2;
    localparam int BTB_BANK_BITS = $clog2(BTB_BANK_NUM);
    localparam int BTB_TAG_WIDTH = 10;
    localparam int BTB_DATA_WIDTH = 16;
    localparam int BTB_QUEUE_SIZE = 4;

    typedef logic [PC_WIDTH-1:0] PcPath;
    typedef logic [BTB_INDEX_WIDTH-1:0] BtbIndexPath;
    typedef logic [BTB_TAG_WIDTH-1:0] BtbTagPath;
    typedef logic [BTB_DATA_WIDTH-1:0] BtbDataPath;

    // One stored entry, 28 bits
    typedef struct packed {
        logic valid;
        logic isCondBr;
        BtbTagPath tag;
        BtbDataPath data;
    } BtbEntry;

    // Deferred write held in the queue
    typedef struct packed {
        BtbIndexPath index;
        BtbEntry entry;
    } BtbWrite;

    typedef struct packed {
        logic valid;
        logic taken;
        logic isCondBr;
        PcPath brAddr;
        PcPath nextAddr;
    } BranchResult;

    typedef struct packed {
        logic hit;
        logic isCondBr;
        PcPath target;
    } FetchPrediction;

    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } BtbInitState;

    function automatic BtbIndexPath toIndex(PcPath pc);
        return pc[INSN_OFFSET +: BTB_INDEX_WIDTH];
    endfunction

    function automatic BtbTagPath toTag(PcPath pc);
        return pc[INSN_OFFSET + BTB_INDEX_WIDTH +: BTB_TAG_WIDTH];
    endfunction

    function automatic BtbDataPath toData(PcPath target);
        return target[INSN_OFFSET +: BTB_DATA_WIDTH];
    endfunction

    // Upper bits come from the fetch PC, targets are word aligned
    function automatic PcPath toTarget(BtbDataPath data, PcPath pc);
        return {pc[PC_WIDTH-1:INSN_OFFSET + BTB_DATA_WIDTH], data, {INSN_OFFSET{1'b0}}};
    endfunction

    function automatic logic isBankConflict(BtbIndexPath a, BtbIndexPath b);
        return a[BTB_BANK_BITS-1:0] == b[BTB_BANK_BITS-1:0];
    endfunction

endpackage

// File: hw/multiBankRam.sv
`timescale 1ns/100ps
// Banked entry storage with synchronous reads.
// The low index bits pick the bank; each write port must hit its own bank.
// Read data appears one cycle after the address, old contents on collision.
module multiBankRam #(
    parameter int ENTRY_NUM = 64,
    parameter int ENTRY_BITS = 28,
    parameter int READ_NUM = 2,
    parameter int WRITE_NUM = 2
) (
    input  logic clk,
    input  logic we [WRITE_NUM],
    input  btbPkg::BtbIndexPath wa [WRITE_NUM],
    input  logic [ENTRY_BITS-1:0] wv [WRITE_NUM],
    input  btbPkg::BtbIndexPath ra [READ_NUM],
    output logic [ENTRY_BITS-1:0] rv [READ_NUM]
);

    localparam int BANK_NUM = btbPkg::BTB_BANK_NUM;
    localparam int BANK_BITS = btbPkg::BTB_BANK_BITS;
    localparam int ROW_NUM = ENTRY_NUM / BANK_NUM;
    localparam int ROW_BITS = btbPkg::BTB_INDEX_WIDTH - BANK_BITS;

    typedef logic [BANK_BITS-1:0] BankSel;
    typedef logic [ROW_BITS-1:0] RowSel;

    // Per bank read words, one per read port
    logic [ENTRY_BITS-1:0] bankRv [BANK_NUM][READ_NUM];
    // Bank each read port addressed last cycle
    BankSel rdBankReg [READ_NUM];

    function automatic BankSel bankOf(btbPkg::BtbIndexPath idx);
        return idx[BANK_BITS-1:0];
    endfunction

    function automatic RowSel rowOf(btbPkg::BtbIndexPath idx);
        return idx[btbPkg::BTB_INDEX_WIDTH-1:BANK_BITS];
    endfunction

    for (genvar b = 0; b < BANK_NUM; b++) begin : genBank
        logic [ENTRY_BITS-1:0] mem [ROW_NUM];

        always_ff @(posedge clk) begin
            // Route every write port aimed at this bank
            for (int p = 0; p < WRITE_NUM; p++) begin
                if (we[p] && bankOf(wa[p]) == BankSel'(b)) begin
                    mem[rowOf(wa[p])] <= wv[p];
                end
            end
            // Every bank reads for every port, the mux picks later
            for (int p = 0; p < READ_NUM; p++) begin
                bankRv[b][p] <= mem[rowOf(ra[p])];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < READ_NUM; p++) begin
            rdBankReg[p] <= bankOf(ra[p]);
        end
    end

    // Output select by the registered bank
    always_comb begin
        for (int p = 0; p < READ_NUM; p++) begin
            rv[p] = bankRv[rdBankReg[p]][p];
        end
    end

endmodule

// File: hw/queuePointer.sv
`timescale 1ns/100ps
// Head and tail pointers for a circular queue whose storage lives elsewhere.
// Push while full and pop while empty are ignored.
module queuePointer #(
    parameter int SIZE = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  logic pop,
    output logic full,
    output logic empty,
    output logic [$clog2(SIZE)-1:0] headPtr,
    output logic [$clog2(SIZE)-1:0] tailPtr
);

    localparam int PTR_BITS = $clog2(SIZE);
    localparam int COUNT_BITS = $clog2(SIZE + 1);

    typedef logic [PTR_BITS-1:0] PtrPath;

    logic [COUNT_BITS-1:0] count;
    logic doPush;
    logic doPop;

    // Wraps for sizes that are not a power of two
    function automatic PtrPath nextPtr(PtrPath ptr);
        return (ptr == PtrPath'(SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == COUNT_BITS'(SIZE));
    assign empty = (count == '0);
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (doPop) begin
                headPtr <= nextPtr(headPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/branchTargetBuffer.sv
`timescale 1ns/100ps
// Branch target buffer core for two fetch slots.
// Looks up both slot PCs, filters taken results into writes, defers
// same-bank collisions through a queue and clears all entries after reset.
module branchTargetBuffer #(
    parameter int QUEUE_SIZE = 4
) (
    input  logic clk,
    input  logic rstN,
    input  btbPkg::PcPath fetchPc,
    input  btbPkg::BranchResult brResult [btbPkg::RESOLVE_WIDTH],
    input  logic [$bits(btbPkg::BtbEntry)-1:0] rv [btbPkg::FETCH_WIDTH],
    input  logic full,
    input  logic empty,
    input  logic [$clog2(QUEUE_SIZE)-1:0] headPtr,
    input  logic [$clog2(QUEUE_SIZE)-1:0] tailPtr,
    output logic we [btbPkg::RESOLVE_WIDTH],
    output btbPkg::BtbIndexPath wa [btbPkg::RESOLVE_WIDTH],
    output logic [$bits(btbPkg::BtbEntry)-1:0] wv [btbPkg::RESOLVE_WIDTH],
    output btbPkg::BtbIndexPath ra [btbPkg::FETCH_WIDTH],
    output logic push,
    output logic pop,
    output btbPkg::FetchPrediction prediction [btbPkg::FETCH_WIDTH],
    output logic initBusy
);

    localparam int FETCH_WIDTH = btbPkg::FETCH_WIDTH;
    localparam int RESOLVE_WIDTH = btbPkg::RESOLVE_WIDTH;

    // Slot PCs, held for the tag compare in the next cycle
    btbPkg::PcPath slotPcNext [FETCH_WIDTH];
    btbPkg::PcPath slotPc [FETCH_WIDTH];
    btbPkg::BtbEntry rdEntry [FETCH_WIDTH];
    // Lookup was issued after the sweep finished
    logic lookupLive;

    btbPkg::BtbInitState initState;
    btbPkg::BtbIndexPath initIndex;

    // Deferred writes
    btbPkg::BtbWrite queueMem [QUEUE_SIZE];
    btbPkg::BtbWrite queueIn;
    btbPkg::BtbWrite queueHead;

    btbPkg::BtbEntry wEntry [RESOLVE_WIDTH];
    logic headBlocked;
    logic drained;

    // Read addresses for consecutive instruction slots
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slotPcNext[i] = fetchPc + btbPkg::PcPath'(i * btbPkg::INSN_BYTES);
            ra[i] = btbPkg::toIndex(slotPcNext[i]);
        end
    end

    always_ff @(posedge clk) begin
        slotPc <= slotPcNext;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            initState <= btbPkg::INIT_SWEEP;
            initIndex <= '0;
            lookupLive <= 1'b0;
        end else begin
            lookupLive <= (initState == btbPkg::INIT_DONE);
            if (initState == btbPkg::INIT_SWEEP) begin
                initIndex <= initIndex + 1'b1;
                // Last index cleared this cycle
                if (initIndex == btbPkg::BtbIndexPath'(btbPkg::BTB_ENTRY_NUM - 1)) begin
                    initState <= btbPkg::INIT_DONE;
                end
            end
        end
    end

    assign initBusy = (initState == btbPkg::INIT_SWEEP);

    // Hit check and target rebuild
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rdEntry[i] = btbPkg::BtbEntry'(rv[i]);
            prediction[i].hit = lookupLive && rdEntry[i].valid &&
                (rdEntry[i].tag == btbPkg::toTag(slotPc[i]));
            prediction[i].isCondBr = rdEntry[i].isCondBr;
            prediction[i].target = btbPkg::toTarget(rdEntry[i].data, slotPc[i]);
        end
    end

    assign queueHead = queueMem[headPtr];

    always_ff @(posedge clk) begin
        if (push && !full) begin
            queueMem[tailPtr] <= queueIn;
        end
    end

    always_comb begin
        push = 1'b0;
        pop = 1'b0;
        queueIn = '0;
        headBlocked = 1'b0;
        drained = 1'b0;

        // Only valid taken results update the buffer
        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            we[i] = brResult[i].valid && brResult[i].taken;
            wa[i] = btbPkg::toIndex(brResult[i].brAddr);
            wEntry[i].valid = 1'b1;
            wEntry[i].isCondBr = brResult[i].isCondBr;
            wEntry[i].tag = btbPkg::toTag(brResult[i].brAddr);
            wEntry[i].data = btbPkg::toData(brResult[i].nextAddr);
        end

        // Later port colliding with an earlier enabled one goes to the queue
        for (int i = 1; i < RESOLVE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (we[i] && we[j] && btbPkg::isBankConflict(wa[i], wa[j])) begin
                    we[i] = 1'b0;
                    push = 1'b1;
                    queueIn.index = wa[i];
                    queueIn.entry = wEntry[i];
                end
            end
        end

        // Head may only take a bank no enabled port is using
        for (int j = 0; j < RESOLVE_WIDTH; j++) begin
            if (we[j] && btbPkg::isBankConflict(queueHead.index, wa[j])) begin
                headBlocked = 1'b1;
            end
        end

        // Lowest idle port takes the head
        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            if (!empty && !headBlocked && !drained && !we[i]) begin
                we[i] = 1'b1;
                wa[i] = queueHead.index;
                wEntry[i] = queueHead.entry;
                drained = 1'b1;
                pop = 1'b1;
            end
        end

        // Sweep owns port 0 and silences everything else
        if (initState == btbPkg::INIT_SWEEP) begin
            for (int i = 0; i < RESOLVE_WIDTH; i++) begin
                we[i] = (i == 0);
                wa[i] = initIndex;
                wEntry[i] = '0;
            end
            push = 1'b0;
            pop = 1'b0;
        end

        for (int i = 0; i < RESOLVE_WIDTH; i++) begin
            wv[i] = wEntry[i];
        end
    end

endmodule

// File: hw/btbTop.sv
`timescale 1ns/100ps
// Branch target buffer top level.
// Wires the core to its banked entry array and queue pointers.
module btbTop #(
    parameter int QUEUE_SIZE = btbPkg::BTB_QUEUE_SIZE
) (
    input  logic clk,
    input  logic rstN,
    input  btbPkg::PcPath fetchPc,
    input  btbPkg::BranchResult brResult [btbPkg::RESOLVE_WIDTH],
    output btbPkg::FetchPrediction prediction [btbPkg::FETCH_WIDTH],
    output logic initBusy
);

    localparam int ENTRY_BITS = $bits(btbPkg::BtbEntry);
    localparam int PTR_BITS = $clog2(QUEUE_SIZE);

    // Entry array ports
    logic we [btbPkg::RESOLVE_WIDTH];
    btbPkg::BtbIndexPath wa [btbPkg::RESOLVE_WIDTH];
    logic [ENTRY_BITS-1:0] wv [btbPkg::RESOLVE_WIDTH];
    btbPkg::BtbIndexPath ra [btbPkg::FETCH_WIDTH];
    logic [ENTRY_BITS-1:0] rv [btbPkg::FETCH_WIDTH];

    // Deferral queue control
    logic push;
    logic pop;
    logic full;
    logic empty;
    logic [PTR_BITS-1:0] headPtr;
    logic [PTR_BITS-1:0] tailPtr;

    branchTargetBuffer #(
        .QUEUE_SIZE(QUEUE_SIZE)
    ) btbCore (
        .clk(clk),
        .rstN(rstN),
        .fetchPc(fetchPc),
        .brResult(brResult),
        .rv(rv),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr),
        .we(we),
        .wa(wa),
        .wv(wv),
        .ra(ra),
        .push(push),
        .pop(pop),
        .prediction(prediction),
        .initBusy(initBusy)
    );

    multiBankRam #(
        .ENTRY_NUM(btbPkg::BTB_ENTRY_NUM),
        .ENTRY_BITS(ENTRY_BITS),
        .READ_NUM(btbPkg::FETCH_WIDTH),
        .WRITE_NUM(btbPkg::RESOLVE_WIDTH)
    ) btbEntryArray (
        .clk(clk),
        .we(we),
        .wa(wa),
        .wv(wv),
        .ra(ra),
        .rv(rv)
    );

    queuePointer #(
        .SIZE(QUEUE_SIZE)
    ) btbQueuePointer (
        .clk(clk),
        .rstN(rstN),
        .push(push),
        .pop(pop),
        .full(full),
        .empty(empty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/100ps
// Testbench clock and reset source.
// Reset is released on a rising edge after RESET_CYCLES cycles.
module clockGen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: sim/btbTop_properties.sv
`timescale 1ns/100ps
// Concurrent checks on the branch target buffer, bound into btbTop.
// Covers queue overflow, bank clashes on the write ports and the sweep.
module btbTopProperties (
    input logic clk,
    input logic rstN,
    input logic push,
    input logic full,
    input logic we [btbPkg::RESOLVE_WIDTH],
    input btbPkg::BtbIndexPath wa [btbPkg::RESOLVE_WIDTH],
    input btbPkg::FetchPrediction prediction [btbPkg::FETCH_WIDTH],
    input btbPkg::BtbInitState initState
);

    localparam int BANK_BITS = btbPkg::BTB_BANK_BITS;

    logic bankClash;
    logic anyHit;

    always_comb begin
        bankClash = 1'b0;
        anyHit = 1'b0;
        for (int i = 1; i < btbPkg::RESOLVE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (we[i] && we[j] && wa[i][BANK_BITS-1:0] == wa[j][BANK_BITS-1:0]) begin
                    bankClash = 1'b1;
                end
            end
        end
        for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
            anyHit = anyHit | prediction[i].hit;
        end
    end

    pushNotFull: assert property (@(posedge clk) disable iff (!rstN) !(push && full))
        else $error("deferral queue pushed while full");

    oneWritePerBank: assert property (@(posedge clk) disable iff (!rstN) !bankClash)
        else $error("two enabled write ports address the same bank");

    // Nothing may hit before every entry is cleared
    noHitInSweep: assert property (@(posedge clk) disable iff (!rstN)
        (initState == btbPkg::INIT_SWEEP) |-> !anyHit)
        else $error("prediction hit during the initialization sweep");

endmodule

bind btbTop btbTopProperties props0 (
    .clk(clk),
    .rstN(rstN),
    .push(push),
    .full(full),
    .we(we),
    .wa(wa),
    .prediction(prediction),
    .initState(btbCore.initState)
);

// File: sim/btbTb.sv
`timescale 1ns/100ps
// Testbench for the branch target buffer.
// Runs a fixed table of writes and lookups, then random rows whose
// expected lookups come from a small model of the entry array.
module btbTb;

    localparam int FIXED_ROWS = 10;
    localparam int RANDOM_ROWS = 48;
    localparam int ROW_TOTAL = FIXED_ROWS + RANDOM_ROWS;
    localparam btbPkg::FetchPrediction MISS = '0;

    // Stimulus, idle cycles before the check and expected lookups
    typedef struct packed {
        logic useModel;
        logic [3:0] idle;
        btbPkg::PcPath fetchPc;
        btbPkg::BranchResult [btbPkg::RESOLVE_WIDTH-1:0] br;
        btbPkg::FetchPrediction [btbPkg::FETCH_WIDTH-1:0] expPred;
    } TableRow;

    logic clk;
    logic rstN;
    btbPkg::PcPath fetchPc;
    btbPkg::BranchResult brResult [btbPkg::RESOLVE_WIDTH];
    btbPkg::FetchPrediction prediction [btbPkg::FETCH_WIDTH];
    logic initBusy;

    TableRow rows [ROW_TOTAL];
    btbPkg::BtbEntry model [btbPkg::BTB_ENTRY_NUM];
    int cycleCount = 0;
    int cycleLimit = 0;
    int modelHits = 0;

    clockGen #(.HALF_PERIOD(10), .RESET_CYCLES(4)) clkGen0 (.clk(clk), .rstN(rstN));

    btbTop dut0 (
        .clk(clk),
        .rstN(rstN),
        .fetchPc(fetchPc),
        .brResult(brResult),
        .prediction(prediction),
        .initBusy(initBusy)
    );

    task automatic failNow(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic btbPkg::BranchResult makeResult(logic valid, logic taken, logic isCondBr,
                                                       btbPkg::PcPath brAddr,
                                                       btbPkg::PcPath nextAddr);
        return '{valid, taken, isCondBr, brAddr, nextAddr};
    endfunction

    function automatic btbPkg::FetchPrediction hitPred(logic isCondBr, btbPkg::PcPath target);
        return '{1'b1, isCondBr, target};
    endfunction

    // Four tags over sixteen indices so entries get reused and replaced
    function automatic btbPkg::PcPath randomPc();
        return 32'h8000_0000 | (($urandom % 4) << 8) | (($urandom % 16) << 2);
    endfunction

    function automatic void setRow(int n, btbPkg::PcPath pc, btbPkg::BranchResult b0,
                                   btbPkg::BranchResult b1, int idle,
                                   btbPkg::FetchPrediction p0, btbPkg::FetchPrediction p1);
        rows[n] = '0;
        rows[n].idle = 4'(idle);
        rows[n].fetchPc = pc;
        rows[n].br[0] = b0;
        rows[n].br[1] = b1;
        rows[n].expPred[0] = p0;
        rows[n].expPred[1] = p1;
    endfunction

    function automatic void fillTable();
        btbPkg::BranchResult none;
        none = '0;
        // Swept buffer misses everywhere
        setRow(0, 32'h0000_1000, none, none, 0, MISS, MISS);
        setRow(1, 32'h0004_2200, none, none, 0, MISS, MISS);
        // Taken branch at index 16 seen from slot 0 and then from slot 1
        setRow(2, 32'h8001_2340, makeResult(1'b1, 1'b1, 1'b1, 32'h8001_2340, 32'h8001_5678),
               none, 1, hitPred(1'b1, 32'h8001_5678), MISS);
        setRow(3, 32'h8001_233c, none, none, 0, MISS, hitPred(1'b1, 32'h8001_5678));
        // Not taken and not valid results write nothing
        setRow(4, 32'h8001_2400, makeResult(1'b1, 1'b0, 1'b0, 32'h8001_2400, 32'h8001_9000),
               makeResult(1'b0, 1'b1, 1'b0, 32'h8001_2404, 32'h8001_9100), 1, MISS, MISS);
        // Same bank pair where port 1 lands later through the queue
        setRow(5, 32'h0000_3014, makeResult(1'b1, 1'b1, 1'b0, 32'h0000_3010, 32'h0000_7700),
               makeResult(1'b1, 1'b1, 1'b1, 32'h0000_3018, 32'h0000_7800), 2,
               MISS, hitPred(1'b1, 32'h0000_7800));
        setRow(6, 32'h0000_3010, none, none, 0, hitPred(1'b0, 32'h0000_7700), MISS);
        // Different banks both write in the same cycle
        setRow(7, 32'h0000_5020, makeResult(1'b1, 1'b1, 1'b0, 32'h0000_5020, 32'h0000_5100),
               makeResult(1'b1, 1'b1, 1'b0, 32'h0000_5024, 32'h0000_5200), 1,
               hitPred(1'b0, 32'h0000_5100), hitPred(1'b0, 32'h0000_5200));
        // New tag at index 16 evicts the branch of row 2
        setRow(8, 32'h8002_2340, makeResult(1'b1, 1'b1, 1'b1, 32'h8002_2340, 32'h8002_a000),
               none, 1, hitPred(1'b1, 32'h8002_a000), MISS);
        setRow(9, 32'h8001_2340, none, none, 0, MISS, MISS);
        for (int n = FIXED_ROWS; n < ROW_TOTAL; n++) begin
            rows[n] = '0;
            rows[n].useModel = 1'b1;
            rows[n].idle = 4'(2 + $urandom % 2);
            rows[n].fetchPc = randomPc();
            for (int i = 0; i < btbPkg::RESOLVE_WIDTH; i++) begin
                rows[n].br[i] = makeResult($urandom % 4 != 0, $urandom % 4 != 0,
                                           $urandom % 2 == 1, randomPc(),
                                           $urandom & 32'hffff_fffc);
            end
        end
    endfunction

    // Reset cycles plus one drive, the idle cycles and one read per row
    function automatic int tableCycles();
        int total;
        total = 4;
        for (int n = 0; n < ROW_TOTAL; n++) begin
            total += int'(rows[n].idle) + 2;
        end
        return total;
    endfunction

    // Index is PC bits 7..2, tag bits 17..8, stored target bits 17..2
    function automatic void updateModel(btbPkg::BranchResult [btbPkg::RESOLVE_WIDTH-1:0] br);
        for (int i = 0; i < btbPkg::RESOLVE_WIDTH; i++) begin
            if (br[i].valid && br[i].taken) begin
                model[br[i].brAddr[7:2]] = '{1'b1, br[i].isCondBr, br[i].brAddr[17:8],
                                             br[i].nextAddr[17:2]};
            end
        end
    endfunction

    function automatic btbPkg::FetchPrediction lookupModel(btbPkg::PcPath pc);
        btbPkg::BtbEntry e;
        btbPkg::FetchPrediction p;
        e = model[pc[7:2]];
        p.hit = e.valid && e.tag == pc[17:8];
        p.isCondBr = e.isCondBr;
        p.target = {pc[31:18], e.data, 2'b00};
        return p;
    endfunction

    task automatic comparePrediction(input btbPkg::FetchPrediction got,
                                     input btbPkg::FetchPrediction exp, input int slot);
        if (got.hit !== exp.hit) begin
            failNow($sformatf("[FAIL] %0t prediction[%0d].hit: got %b expected %b",
                              $time, slot, got.hit, exp.hit));
        end else if (exp.hit && got.isCondBr !== exp.isCondBr) begin
            failNow($sformatf("[FAIL] %0t prediction[%0d].isCondBr: got %b expected %b",
                              $time, slot, got.isCondBr, exp.isCondBr));
        end else if (exp.hit && got.target !== exp.target) begin
            failNow($sformatf("[FAIL] %0t prediction[%0d].target: got %h expected %h",
                              $time, slot, got.target, exp.target));
        end
    endtask

    task automatic compareInit(input logic got, input logic exp);
        if (got !== exp) begin
            failNow($sformatf("[FAIL] %0t initBusy: got %b expected %b", $time, got, exp));
        end
    endtask

    task automatic applyRow(input int n);
        btbPkg::FetchPrediction exp;
        @(posedge clk);
        fetchPc <= rows[n].fetchPc;
        for (int i = 0; i < btbPkg::RESOLVE_WIDTH; i++) begin
            brResult[i] <= rows[n].br[i];
        end
        updateModel(rows[n].br);
        // Fetch PC stays put while the writes and any drain settle
        repeat (int'(rows[n].idle) + 1) begin
            @(posedge clk);
            for (int i = 0; i < btbPkg::RESOLVE_WIDTH; i++) begin
                brResult[i] <= '0;
            end
        end
        @(negedge clk);
        for (int i = 0; i < btbPkg::FETCH_WIDTH; i++) begin
            exp = rows[n].useModel ? lookupModel(rows[n].fetchPc + 32'(i * 4))
                                   : rows[n].expPred[i];
            if (rows[n].useModel && exp.hit) begin
                modelHits++;
            end
            comparePrediction(prediction[i], exp, i);
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            failNow($sformatf("Run did not finish within %0d clock cycles", cycleLimit));
        end
    end

    initial begin
        fetchPc = '0;
        for (int i = 0; i < btbPkg::RESOLVE_WIDTH; i++) begin
            brResult[i] = '0;
        end
        for (int i = 0; i < btbPkg::BTB_ENTRY_NUM; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'h110a));
        fillTable();
        cycleLimit = btbPkg::BTB_ENTRY_NUM + tableCycles() + 50;

        @(posedge clk);
        @(negedge clk);
        compareInit(initBusy, 1'b1);
        wait (rstN === 1'b1);
        @(negedge clk);
        // Lookups stay dark while one index is cleared per cycle
        for (int c = 0; c < btbPkg::BTB_ENTRY_NUM; c++) begin
            compareInit(initBusy, 1'b1);
            comparePrediction(prediction[0], MISS, 0);
            comparePrediction(prediction[1], MISS, 1);
            @(negedge clk);
        end
        compareInit(initBusy, 1'b0);

        for (int n = 0; n < ROW_TOTAL; n++) begin
            applyRow(n);
        end
        if (modelHits == 0) begin
            failNow("Random rows never produced a hit, so the model check proved nothing");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: btbSubsystem.f
hw/btbPkg.sv
hw/multiBankRam.sv
hw/queuePointer.sv
hw/branchTargetBuffer.sv
hw/btbTop.sv
sim/clockGen.sv
sim/btbTop_properties.sv
sim/btbTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the branch target buffer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module btbTb -f btbSubsystem.f -o btbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/btbSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" <<< "$output"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
